//--- dma_ctrl_pkg.sv
// DMA control package with bus widths, register offsets and register select codes
package dma_ctrl_pkg;

    typedef logic [15:0] reg_addr_t;
    typedef logic [31:0] reg_data_t;
    typedef logic [63:0] pcie_addr_t;
    typedef logic [31:0] axi_addr_t;
    typedef logic [15:0] dma_len_t;
    typedef logic [7:0]  dma_tag_t;
    typedef logic [31:0] count_t;

    localparam int ERR_SRC_COUNT     = 3;
    localparam int MERGE_COUNT_WIDTH = 4;
    localparam int STATUS_VALID_BIT  = 31;

    localparam reg_addr_t ADDR_ENABLE     = 16'h0000;

    // read descriptor
    localparam reg_addr_t ADDR_RD_PCIE_LO = 16'h0100;
    localparam reg_addr_t ADDR_RD_PCIE_HI = 16'h0104;
    localparam reg_addr_t ADDR_RD_AXI     = 16'h0108;
    localparam reg_addr_t ADDR_RD_LEN     = 16'h0110;
    localparam reg_addr_t ADDR_RD_TAG     = 16'h0114;
    localparam reg_addr_t ADDR_RD_STATUS  = 16'h0118;

    // write descriptor
    localparam reg_addr_t ADDR_WR_PCIE_LO = 16'h0200;
    localparam reg_addr_t ADDR_WR_PCIE_HI = 16'h0204;
    localparam reg_addr_t ADDR_WR_AXI     = 16'h0208;
    localparam reg_addr_t ADDR_WR_LEN     = 16'h0210;
    localparam reg_addr_t ADDR_WR_TAG     = 16'h0214;
    localparam reg_addr_t ADDR_WR_STATUS  = 16'h0218;

    // read-only packet counters
    localparam reg_addr_t ADDR_CNT_RQ     = 16'h0400;
    localparam reg_addr_t ADDR_CNT_RC     = 16'h0404;
    localparam reg_addr_t ADDR_CNT_CQ     = 16'h0408;
    localparam reg_addr_t ADDR_CNT_CC     = 16'h040C;

    typedef enum logic [4:0] {
        SEL_NONE,
        SEL_ENABLE,
        SEL_RD_PCIE_LO, SEL_RD_PCIE_HI, SEL_RD_AXI, SEL_RD_LEN, SEL_RD_TAG, SEL_RD_STATUS,
        SEL_WR_PCIE_LO, SEL_WR_PCIE_HI, SEL_WR_AXI, SEL_WR_LEN, SEL_WR_TAG, SEL_WR_STATUS,
        SEL_CNT_RQ, SEL_CNT_RC, SEL_CNT_CQ, SEL_CNT_CC
    } reg_sel_t;

endpackage

//--- ctrl_decode.sv
// Register bus handshake and address decode into single-cycle register accesses
module ctrl_decode (
    input  logic                    clk,
    input  logic                    rst,
    input  dma_ctrl_pkg::reg_addr_t awaddr,
    input  logic                    awvalid,
    output logic                    awready,
    input  logic                    wvalid,
    output logic                    wready,
    output logic                    bvalid,
    input  logic                    bready,
    input  dma_ctrl_pkg::reg_addr_t araddr,
    input  logic                    arvalid,
    output logic                    arready,
    output logic                    rvalid,
    input  logic                    rready,
    output logic                    wr_en,
    output dma_ctrl_pkg::reg_sel_t  wr_sel,
    output logic                    rd_en,
    output dma_ctrl_pkg::reg_sel_t  rd_sel
);
    import dma_ctrl_pkg::*;

    function automatic reg_sel_t decode_addr(input reg_addr_t addr);
        reg_addr_t word_addr;
        word_addr = {addr[15:2], 2'b00};
        case (word_addr)
            ADDR_ENABLE:     return SEL_ENABLE;
            ADDR_RD_PCIE_LO: return SEL_RD_PCIE_LO;
            ADDR_RD_PCIE_HI: return SEL_RD_PCIE_HI;
            ADDR_RD_AXI:     return SEL_RD_AXI;
            ADDR_RD_LEN:     return SEL_RD_LEN;
            ADDR_RD_TAG:     return SEL_RD_TAG;
            ADDR_RD_STATUS:  return SEL_RD_STATUS;
            ADDR_WR_PCIE_LO: return SEL_WR_PCIE_LO;
            ADDR_WR_PCIE_HI: return SEL_WR_PCIE_HI;
            ADDR_WR_AXI:     return SEL_WR_AXI;
            ADDR_WR_LEN:     return SEL_WR_LEN;
            ADDR_WR_TAG:     return SEL_WR_TAG;
            ADDR_WR_STATUS:  return SEL_WR_STATUS;
            ADDR_CNT_RQ:     return SEL_CNT_RQ;
            ADDR_CNT_RC:     return SEL_CNT_RC;
            ADDR_CNT_CQ:     return SEL_CNT_CQ;
            ADDR_CNT_CC:     return SEL_CNT_CC;
            default:         return SEL_NONE;
        endcase
    endfunction

    // accept only while no response is outstanding
    assign wr_en  = awvalid && wvalid && !bvalid;
    assign rd_en  = arvalid && !rvalid;
    assign wr_sel = decode_addr(awaddr);
    assign rd_sel = decode_addr(araddr);

    always_ff @(posedge clk) begin
        if (rst) begin
            awready <= 1'b0;
            wready  <= 1'b0;
            bvalid  <= 1'b0;
            arready <= 1'b0;
            rvalid  <= 1'b0;
        end else begin
            awready <= wr_en;
            wready  <= wr_en;
            bvalid  <= wr_en || (bvalid && !bready);
            arready <= rd_en;
            rvalid  <= rd_en || (rvalid && !rready);
        end
    end

endmodule

//--- desc_regs.sv
// DMA enable and read/write descriptor registers, launched by tag writes
module desc_regs (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     wr_en,
    input  dma_ctrl_pkg::reg_sel_t   wr_sel,
    input  dma_ctrl_pkg::reg_data_t  wdata,
    output logic                     dma_enable,
    output dma_ctrl_pkg::pcie_addr_t rd_desc_pcie_addr,
    output dma_ctrl_pkg::axi_addr_t  rd_desc_axi_addr,
    output dma_ctrl_pkg::dma_len_t   rd_desc_len,
    output dma_ctrl_pkg::dma_tag_t   rd_desc_tag,
    output logic                     rd_desc_valid,
    input  logic                     rd_desc_ready,
    output dma_ctrl_pkg::pcie_addr_t wr_desc_pcie_addr,
    output dma_ctrl_pkg::axi_addr_t  wr_desc_axi_addr,
    output dma_ctrl_pkg::dma_len_t   wr_desc_len,
    output dma_ctrl_pkg::dma_tag_t   wr_desc_tag,
    output logic                     wr_desc_valid,
    input  logic                     wr_desc_ready
);
    import dma_ctrl_pkg::*;

    logic rd_tag_wr;
    logic wr_tag_wr;

    assign rd_tag_wr = wr_en && (wr_sel == SEL_RD_TAG);
    assign wr_tag_wr = wr_en && (wr_sel == SEL_WR_TAG);

    // control state
    always_ff @(posedge clk) begin
        if (rst) begin
            dma_enable    <= 1'b0;
            rd_desc_valid <= 1'b0;
            wr_desc_valid <= 1'b0;
        end else begin
            if (wr_en && (wr_sel == SEL_ENABLE)) begin
                dma_enable <= wdata[0];
            end
            // a new tag write keeps valid high with the new tag
            rd_desc_valid <= rd_tag_wr || (rd_desc_valid && !rd_desc_ready);
            wr_desc_valid <= wr_tag_wr || (wr_desc_valid && !wr_desc_ready);
        end
    end

    // descriptor fields
    always_ff @(posedge clk) begin
        if (wr_en) begin
            case (wr_sel)
                SEL_RD_PCIE_LO: rd_desc_pcie_addr[31:0]  <= wdata;
                SEL_RD_PCIE_HI: rd_desc_pcie_addr[63:32] <= wdata;
                SEL_RD_AXI:     rd_desc_axi_addr         <= axi_addr_t'(wdata);
                SEL_RD_LEN:     rd_desc_len              <= dma_len_t'(wdata);
                SEL_RD_TAG:     rd_desc_tag              <= dma_tag_t'(wdata);
                SEL_WR_PCIE_LO: wr_desc_pcie_addr[31:0]  <= wdata;
                SEL_WR_PCIE_HI: wr_desc_pcie_addr[63:32] <= wdata;
                SEL_WR_AXI:     wr_desc_axi_addr         <= axi_addr_t'(wdata);
                SEL_WR_LEN:     wr_desc_len              <= dma_len_t'(wdata);
                SEL_WR_TAG:     wr_desc_tag              <= dma_tag_t'(wdata);
                default: begin
                end
            endcase
        end
    end

endmodule

//--- pkt_counters.sv
// Four wrapping packet counters driven by last-beat handshakes on the PCIe streams
module pkt_counters (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 rq_valid,
    input  logic                 rq_ready,
    input  logic                 rq_last,
    input  logic                 rc_valid,
    input  logic                 rc_ready,
    input  logic                 rc_last,
    input  logic                 cq_valid,
    input  logic                 cq_ready,
    input  logic                 cq_last,
    input  logic                 cc_valid,
    input  logic                 cc_ready,
    input  logic                 cc_last,
    output dma_ctrl_pkg::count_t cnt_rq,
    output dma_ctrl_pkg::count_t cnt_rc,
    output dma_ctrl_pkg::count_t cnt_cq,
    output dma_ctrl_pkg::count_t cnt_cc
);

    always_ff @(posedge clk) begin
        if (rst) begin
            cnt_rq <= '0;
            cnt_rc <= '0;
            cnt_cq <= '0;
            cnt_cc <= '0;
        end else begin
            // one count per completed packet
            if (rq_valid && rq_ready && rq_last) begin
                cnt_rq <= cnt_rq + 1'b1;
            end
            if (rc_valid && rc_ready && rc_last) begin
                cnt_rc <= cnt_rc + 1'b1;
            end
            if (cq_valid && cq_ready && cq_last) begin
                cnt_cq <= cnt_cq + 1'b1;
            end
            if (cc_valid && cc_ready && cc_last) begin
                cnt_cc <= cnt_cc + 1'b1;
            end
        end
    end

endmodule

//--- error_pulse_merge.sv
// Error pulse merge that counts pending input pulses and emits one per cycle
module error_pulse_merge #(
    parameter int INPUT_COUNT = dma_ctrl_pkg::ERR_SRC_COUNT
) (
    input  logic                   clk,
    input  logic                   rst,
    input  logic [INPUT_COUNT-1:0] pulse_in,
    output logic                   pulse_out
);
    import dma_ctrl_pkg::*;

    logic [MERGE_COUNT_WIDTH-1:0] in_count;
    logic [MERGE_COUNT_WIDTH-1:0] pend_count;
    logic                         pend_any;

    // number of sources firing this cycle
    always_comb begin
        in_count = '0;
        for (int i = 0; i < INPUT_COUNT; i++) begin
            in_count = in_count + MERGE_COUNT_WIDTH'(pulse_in[i]);
        end
    end

    assign pend_any = (pend_count != '0);

    always_ff @(posedge clk) begin
        if (rst) begin
            pend_count <= '0;
            pulse_out  <= 1'b0;
        end else begin
            // each output pulse retires one pending event
            pulse_out  <= pend_any;
            pend_count <= pend_count + in_count - MERGE_COUNT_WIDTH'(pend_any);
        end
    end

endmodule

//--- read_mux.sv
// Read data selection with registered result and completion status pop
module read_mux (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    rd_en,
    input  dma_ctrl_pkg::reg_sel_t  rd_sel,
    input  logic                    dma_enable,
    input  dma_ctrl_pkg::dma_tag_t  rd_status_tag,
    input  logic                    rd_status_valid,
    input  dma_ctrl_pkg::dma_tag_t  wr_status_tag,
    input  logic                    wr_status_valid,
    input  dma_ctrl_pkg::count_t    cnt_rq,
    input  dma_ctrl_pkg::count_t    cnt_rc,
    input  dma_ctrl_pkg::count_t    cnt_cq,
    input  dma_ctrl_pkg::count_t    cnt_cc,
    output dma_ctrl_pkg::reg_data_t rdata,
    output logic                    rd_status_ready,
    output logic                    wr_status_ready
);
    import dma_ctrl_pkg::*;

    reg_data_t read_word;

    always_comb begin
        read_word = '0;
        case (rd_sel)
            SEL_ENABLE: read_word[0] = dma_enable;
            SEL_RD_STATUS: begin
                read_word = reg_data_t'(rd_status_tag);
                read_word[STATUS_VALID_BIT] = rd_status_valid;
            end
            SEL_WR_STATUS: begin
                read_word = reg_data_t'(wr_status_tag);
                read_word[STATUS_VALID_BIT] = wr_status_valid;
            end
            SEL_CNT_RQ: read_word = reg_data_t'(cnt_rq);
            SEL_CNT_RC: read_word = reg_data_t'(cnt_rc);
            SEL_CNT_CQ: read_word = reg_data_t'(cnt_cq);
            SEL_CNT_CC: read_word = reg_data_t'(cnt_cc);
            default:    read_word = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rd_en) begin
            rdata <= read_word;
        end
    end

    // pop only a status that was actually returned
    always_ff @(posedge clk) begin
        if (rst) begin
            rd_status_ready <= 1'b0;
            wr_status_ready <= 1'b0;
        end else begin
            rd_status_ready <= rd_en && (rd_sel == SEL_RD_STATUS) && rd_status_valid;
            wr_status_ready <= rd_en && (rd_sel == SEL_WR_STATUS) && wr_status_valid;
        end
    end

endmodule

//--- dma_ctrl_core.sv
// PCIe DMA control block with register bus, descriptors, counters and error merge
module dma_ctrl_core (
    input  logic                                   clk,
    input  logic                                   rst,
    input  dma_ctrl_pkg::reg_addr_t                awaddr,
    input  logic                                   awvalid,
    output logic                                   awready,
    input  dma_ctrl_pkg::reg_data_t                wdata,
    input  logic                                   wvalid,
    output logic                                   wready,
    output logic                                   bvalid,
    input  logic                                   bready,
    input  dma_ctrl_pkg::reg_addr_t                araddr,
    input  logic                                   arvalid,
    output logic                                   arready,
    output dma_ctrl_pkg::reg_data_t                rdata,
    output logic                                   rvalid,
    input  logic                                   rready,
    output dma_ctrl_pkg::pcie_addr_t               rd_desc_pcie_addr,
    output dma_ctrl_pkg::axi_addr_t                rd_desc_axi_addr,
    output dma_ctrl_pkg::dma_len_t                 rd_desc_len,
    output dma_ctrl_pkg::dma_tag_t                 rd_desc_tag,
    output logic                                   rd_desc_valid,
    input  logic                                   rd_desc_ready,
    output dma_ctrl_pkg::pcie_addr_t               wr_desc_pcie_addr,
    output dma_ctrl_pkg::axi_addr_t                wr_desc_axi_addr,
    output dma_ctrl_pkg::dma_len_t                 wr_desc_len,
    output dma_ctrl_pkg::dma_tag_t                 wr_desc_tag,
    output logic                                   wr_desc_valid,
    input  logic                                   wr_desc_ready,
    input  dma_ctrl_pkg::dma_tag_t                 rd_status_tag,
    input  logic                                   rd_status_valid,
    output logic                                   rd_status_ready,
    input  dma_ctrl_pkg::dma_tag_t                 wr_status_tag,
    input  logic                                   wr_status_valid,
    output logic                                   wr_status_ready,
    output logic                                   irq,
    output logic                                   dma_enable,
    input  logic                                   rq_valid,
    input  logic                                   rq_ready,
    input  logic                                   rq_last,
    input  logic                                   rc_valid,
    input  logic                                   rc_ready,
    input  logic                                   rc_last,
    input  logic                                   cq_valid,
    input  logic                                   cq_ready,
    input  logic                                   cq_last,
    input  logic                                   cc_valid,
    input  logic                                   cc_ready,
    input  logic                                   cc_last,
    input  logic [dma_ctrl_pkg::ERR_SRC_COUNT-1:0] err_cor_in,
    input  logic [dma_ctrl_pkg::ERR_SRC_COUNT-1:0] err_uncor_in,
    output logic                                   status_error_cor,
    output logic                                   status_error_uncor
);
    import dma_ctrl_pkg::*;

    logic     wr_en;
    logic     rd_en;
    reg_sel_t wr_sel;
    reg_sel_t rd_sel;
    count_t   cnt_rq;
    count_t   cnt_rc;
    count_t   cnt_cq;
    count_t   cnt_cc;

    // raw interrupt level while any completion is pending
    assign irq = rd_status_valid || wr_status_valid;

    ctrl_decode i_ctrl_decode (
        .clk(clk), .rst(rst),
        .awaddr(awaddr), .awvalid(awvalid), .awready(awready),
        .wvalid(wvalid), .wready(wready), .bvalid(bvalid), .bready(bready),
        .araddr(araddr), .arvalid(arvalid), .arready(arready),
        .rvalid(rvalid), .rready(rready),
        .wr_en(wr_en), .wr_sel(wr_sel), .rd_en(rd_en), .rd_sel(rd_sel)
    );

    desc_regs i_desc_regs (
        .clk(clk), .rst(rst),
        .wr_en(wr_en), .wr_sel(wr_sel), .wdata(wdata), .dma_enable(dma_enable),
        .rd_desc_pcie_addr(rd_desc_pcie_addr), .rd_desc_axi_addr(rd_desc_axi_addr),
        .rd_desc_len(rd_desc_len), .rd_desc_tag(rd_desc_tag),
        .rd_desc_valid(rd_desc_valid), .rd_desc_ready(rd_desc_ready),
        .wr_desc_pcie_addr(wr_desc_pcie_addr), .wr_desc_axi_addr(wr_desc_axi_addr),
        .wr_desc_len(wr_desc_len), .wr_desc_tag(wr_desc_tag),
        .wr_desc_valid(wr_desc_valid), .wr_desc_ready(wr_desc_ready)
    );

    read_mux i_read_mux (
        .clk(clk), .rst(rst),
        .rd_en(rd_en), .rd_sel(rd_sel), .dma_enable(dma_enable),
        .rd_status_tag(rd_status_tag), .rd_status_valid(rd_status_valid),
        .wr_status_tag(wr_status_tag), .wr_status_valid(wr_status_valid),
        .cnt_rq(cnt_rq), .cnt_rc(cnt_rc), .cnt_cq(cnt_cq), .cnt_cc(cnt_cc),
        .rdata(rdata), .rd_status_ready(rd_status_ready), .wr_status_ready(wr_status_ready)
    );

    pkt_counters i_pkt_counters (
        .clk(clk), .rst(rst),
        .rq_valid(rq_valid), .rq_ready(rq_ready), .rq_last(rq_last),
        .rc_valid(rc_valid), .rc_ready(rc_ready), .rc_last(rc_last),
        .cq_valid(cq_valid), .cq_ready(cq_ready), .cq_last(cq_last),
        .cc_valid(cc_valid), .cc_ready(cc_ready), .cc_last(cc_last),
        .cnt_rq(cnt_rq), .cnt_rc(cnt_rc), .cnt_cq(cnt_cq), .cnt_cc(cnt_cc)
    );

    error_pulse_merge #(.INPUT_COUNT(ERR_SRC_COUNT)) i_err_cor_merge (
        .clk(clk), .rst(rst), .pulse_in(err_cor_in), .pulse_out(status_error_cor)
    );

    error_pulse_merge #(.INPUT_COUNT(ERR_SRC_COUNT)) i_err_uncor_merge (
        .clk(clk), .rst(rst), .pulse_in(err_uncor_in), .pulse_out(status_error_uncor)
    );

endmodule

//--- tb_dma_ctrl_core.sv
// Data-driven testbench for the DMA control block with bus driver and DMA model
module tb_dma_ctrl_core;
    import dma_ctrl_pkg::*;

    logic clk;
    logic rst;
    reg_addr_t awaddr;
    reg_addr_t araddr;
    reg_data_t wdata;
    reg_data_t rdata;
    logic awvalid, awready, wvalid, wready, bvalid, bready;
    logic arvalid, arready, rvalid, rready;
    pcie_addr_t rd_desc_pcie_addr, wr_desc_pcie_addr;
    axi_addr_t rd_desc_axi_addr, wr_desc_axi_addr;
    dma_len_t rd_desc_len, wr_desc_len;
    dma_tag_t rd_desc_tag, wr_desc_tag, rd_status_tag, wr_status_tag;
    logic rd_desc_valid, rd_desc_ready, wr_desc_valid, wr_desc_ready;
    logic rd_status_valid, rd_status_ready, wr_status_valid, wr_status_ready;
    logic irq, dma_enable;
    // stream order is rq, rc, cq, cc
    logic [3:0] s_valid, s_ready, s_last;
    logic [ERR_SRC_COUNT-1:0] err_cor_in, err_uncor_in;
    logic status_error_cor, status_error_uncor;

    integer seed = 79;
    integer errors = 0;
    integer cor_seen = 0;
    integer uncor_seen = 0;
    integer cor_exp = 0;
    integer uncor_exp = 0;
    pcie_addr_t sh_pcie [2];
    axi_addr_t sh_axi [2];
    dma_len_t sh_len [2];
    dma_tag_t sh_tag [2];

    dma_ctrl_core i_dma_ctrl_core (
        .clk(clk), .rst(rst),
        .awaddr(awaddr), .awvalid(awvalid), .awready(awready),
        .wdata(wdata), .wvalid(wvalid), .wready(wready), .bvalid(bvalid), .bready(bready),
        .araddr(araddr), .arvalid(arvalid), .arready(arready),
        .rdata(rdata), .rvalid(rvalid), .rready(rready),
        .rd_desc_pcie_addr(rd_desc_pcie_addr), .rd_desc_axi_addr(rd_desc_axi_addr),
        .rd_desc_len(rd_desc_len), .rd_desc_tag(rd_desc_tag),
        .rd_desc_valid(rd_desc_valid), .rd_desc_ready(rd_desc_ready),
        .wr_desc_pcie_addr(wr_desc_pcie_addr), .wr_desc_axi_addr(wr_desc_axi_addr),
        .wr_desc_len(wr_desc_len), .wr_desc_tag(wr_desc_tag),
        .wr_desc_valid(wr_desc_valid), .wr_desc_ready(wr_desc_ready),
        .rd_status_tag(rd_status_tag), .rd_status_valid(rd_status_valid),
        .rd_status_ready(rd_status_ready),
        .wr_status_tag(wr_status_tag), .wr_status_valid(wr_status_valid),
        .wr_status_ready(wr_status_ready),
        .irq(irq), .dma_enable(dma_enable),
        .rq_valid(s_valid[0]), .rq_ready(s_ready[0]), .rq_last(s_last[0]),
        .rc_valid(s_valid[1]), .rc_ready(s_ready[1]), .rc_last(s_last[1]),
        .cq_valid(s_valid[2]), .cq_ready(s_ready[2]), .cq_last(s_last[2]),
        .cc_valid(s_valid[3]), .cc_ready(s_ready[3]), .cc_last(s_last[3]),
        .err_cor_in(err_cor_in), .err_uncor_in(err_uncor_in),
        .status_error_cor(status_error_cor), .status_error_uncor(status_error_uncor)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // DMA model pops a completion when it sees status ready
    always @(posedge clk) begin
        if (rd_status_ready) begin
            #1 rd_status_valid = 1'b0;
        end
        if (wr_status_ready) begin
            #1 wr_status_valid = 1'b0;
        end
    end

    always @(posedge clk) begin
        if (!rst) begin
            if (status_error_cor) cor_seen = cor_seen + 1;
            if (status_error_uncor) uncor_seen = uncor_seen + 1;
        end
    end

    task automatic check_value(input string name, input logic [63:0] exp, input logic [63:0] act);
        if (exp !== act) begin
            $display("Fail at %0t: %s expected %h got %h", $time, name, exp, act);
            errors = errors + 1;
        end
    endtask

    task automatic abort_on_timeout(input string what);
        $display("timeout while waiting for %s, %0d errors so far", what, errors);
        $display("Verification failed");
        $finish;
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic bus_write(input reg_addr_t addr, input reg_data_t data);
        integer n;
        awaddr = addr;
        wdata = data;
        awvalid = 1'b1;
        wvalid = 1'b1;
        n = 0;
        do begin
            next_cycle();
            n = n + 1;
        end while (!(awready && wready) && n < 100);
        if (!(awready && wready)) abort_on_timeout("awready and wready");
        awvalid = 1'b0;
        wvalid = 1'b0;
        n = 0;
        while (bvalid && n < 100) begin
            next_cycle();
            n = n + 1;
        end
        if (bvalid) abort_on_timeout("bvalid to drop");
    endtask

    task automatic bus_read(input reg_addr_t addr, output reg_data_t data);
        integer n;
        araddr = addr;
        arvalid = 1'b1;
        n = 0;
        do begin
            next_cycle();
            n = n + 1;
        end while (!arready && n < 100);
        if (!arready) abort_on_timeout("arready");
        arvalid = 1'b0;
        n = 0;
        while (!rvalid && n < 100) begin
            next_cycle();
            n = n + 1;
        end
        if (!rvalid) abort_on_timeout("rvalid");
        data = rdata;
    endtask

    // DMA model takes the read (d = 0) or write (d = 1) descriptor
    task automatic take_descriptor(input integer d);
        integer n;
        integer delay;
        n = 0;
        while (!(d == 0 ? rd_desc_valid : wr_desc_valid) && n < 100) begin
            next_cycle();
            n = n + 1;
        end
        if (!(d == 0 ? rd_desc_valid : wr_desc_valid)) abort_on_timeout("descriptor valid");
        delay = $unsigned($random(seed)) % 4;
        repeat (delay) next_cycle();
        if (d == 1) begin
            // the other descriptor's ready must not retire this one
            rd_desc_ready = 1'b1;
            next_cycle();
            rd_desc_ready = 1'b0;
            check_value("wr_desc_valid", 1, wr_desc_valid);
        end
        check_value("desc_pcie_addr", sh_pcie[d], d == 0 ? rd_desc_pcie_addr : wr_desc_pcie_addr);
        check_value("desc_axi_addr", sh_axi[d], d == 0 ? rd_desc_axi_addr : wr_desc_axi_addr);
        check_value("desc_len", sh_len[d], d == 0 ? rd_desc_len : wr_desc_len);
        check_value("desc_tag", sh_tag[d], d == 0 ? rd_desc_tag : wr_desc_tag);
        if (d == 0) rd_desc_ready = 1'b1;
        else wr_desc_ready = 1'b1;
        next_cycle();
        rd_desc_ready = 1'b0;
        wr_desc_ready = 1'b0;
        check_value("desc_valid", 0, d == 0 ? rd_desc_valid : wr_desc_valid);
    endtask

    task automatic write_op(input reg_addr_t addr, input reg_data_t data);
        integer d;
        d = addr[9] ? 1 : 0;
        bus_write(addr, data);
        case ({addr[15:2], 2'b00})
            ADDR_ENABLE: check_value("dma_enable", data[0], dma_enable);
            ADDR_RD_PCIE_LO, ADDR_WR_PCIE_LO: sh_pcie[d][31:0] = data;
            ADDR_RD_PCIE_HI, ADDR_WR_PCIE_HI: sh_pcie[d][63:32] = data;
            ADDR_RD_AXI, ADDR_WR_AXI: sh_axi[d] = data;
            ADDR_RD_LEN, ADDR_WR_LEN: sh_len[d] = data[15:0];
            ADDR_RD_TAG, ADDR_WR_TAG: begin
                sh_tag[d] = data[7:0];
                take_descriptor(d);
            end
            default: begin
            end
        endcase
    endtask

    task automatic read_op(input reg_addr_t addr, input reg_data_t exp);
        reg_data_t data;
        logic is_rd;
        string ready_name;
        bus_read(addr, data);
        check_value("rdata", exp, data);
        if (addr == ADDR_RD_STATUS || addr == ADDR_WR_STATUS) begin
            is_rd = (addr == ADDR_RD_STATUS);
            ready_name = is_rd ? "rd_status_ready" : "wr_status_ready";
            // status ready pulses with rvalid only for a valid status
            check_value(ready_name, exp[STATUS_VALID_BIT],
                        is_rd ? rd_status_ready : wr_status_ready);
            next_cycle();
            check_value(ready_name, 0, is_rd ? rd_status_ready : wr_status_ready);
            next_cycle();
            // a popped status clears the interrupt
            if (exp[STATUS_VALID_BIT]) check_value("irq", 0, irq);
        end
    endtask

    task automatic send_packets(input integer s, input integer max_beats, input integer count);
        integer p;
        integer b;
        integer beats;
        for (p = 0; p < count; p++) begin
            beats = 1 + $unsigned($random(seed)) % max_beats;
            for (b = 0; b < beats; b++) begin
                if (b == beats - 1) begin
                    // stalled last beat must not count
                    s_valid[s] = 1'b1;
                    s_last[s] = 1'b1;
                    s_ready[s] = 1'b0;
                    next_cycle();
                end
                s_valid[s] = 1'b1;
                s_ready[s] = 1'b1;
                s_last[s] = (b == beats - 1);
                next_cycle();
            end
            s_valid[s] = 1'b0;
            s_ready[s] = 1'b0;
            s_last[s] = 1'b0;
        end
        next_cycle();
    endtask

    task automatic pulse_errors(input logic [ERR_SRC_COUNT-1:0] cor,
                                input logic [ERR_SRC_COUNT-1:0] uncor);
        err_cor_in = cor;
        err_uncor_in = uncor;
        cor_exp = cor_exp + $countones(cor);
        uncor_exp = uncor_exp + $countones(uncor);
        next_cycle();
        err_cor_in = '0;
        err_uncor_in = '0;
    endtask

    task automatic complete_op(input integer d, input dma_tag_t tag);
        if (d == 0) begin
            rd_status_tag = tag;
            rd_status_valid = 1'b1;
        end else begin
            wr_status_tag = tag;
            wr_status_valid = 1'b1;
        end
        next_cycle();
        check_value("irq", 1, irq);
    endtask

    task automatic drain_errors();
        integer n;
        integer idle;
        n = 0;
        idle = 0;
        while (idle < 4 && n < 100) begin
            next_cycle();
            n = n + 1;
            idle = (status_error_cor || status_error_uncor) ? 0 : idle + 1;
        end
        if (idle < 4) abort_on_timeout("error outputs to return low");
        check_value("status_error_cor count", cor_exp, cor_seen);
        check_value("status_error_uncor count", uncor_exp, uncor_seen);
    endtask

    initial begin
        integer fd;
        integer r;
        string line;
        logic [7:0] op;
        logic [31:0] f1, f2, f3;
        rst = 1'b1;
        awaddr = '0;
        araddr = '0;
        wdata = '0;
        awvalid = 1'b0;
        wvalid = 1'b0;
        bready = 1'b1;
        arvalid = 1'b0;
        rready = 1'b1;
        rd_desc_ready = 1'b0;
        wr_desc_ready = 1'b0;
        rd_status_tag = '0;
        rd_status_valid = 1'b0;
        wr_status_tag = '0;
        wr_status_valid = 1'b0;
        s_valid = '0;
        s_ready = '0;
        s_last = '0;
        err_cor_in = '0;
        err_uncor_in = '0;
        repeat (4) @(posedge clk);
        #1 rst = 1'b0;
        next_cycle();
        fd = $fopen("dma_ctrl_stimulus.txt", "r");
        if (fd == 0) begin
            $display("cannot open the stimulus file");
            $display("Verification failed");
            $finish;
        end
        while (!$feof(fd)) begin
            r = $fgets(line, fd);
            if (r > 1 && line.getc(0) != "#") begin
                f1 = 0;
                f2 = 0;
                f3 = 0;
                r = $sscanf(line, "%c %h %h %h", op, f1, f2, f3);
                case (op)
                    "W": write_op(f1[15:0], f2);
                    "R": read_op(f1[15:0], f2);
                    "E": pulse_errors(f1[2:0], f2[2:0]);
                    "P": send_packets(f1, f2, f3);
                    "C": complete_op(f1, f2[7:0]);
                    default: begin
                        $display("unknown operation in line: %s", line);
                        errors = errors + 1;
                    end
                endcase
            end
        end
        $fclose(fd);
        drain_errors();
        $display("checks done with %0d errors", errors);
        if (errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

//--- dma_ctrl_stimulus.txt
# W addr data | R addr expected | E cor_mask uncor_mask | P stream max_beats count
# C desc(0 rd, 1 wr) tag | all fields hex, stream 0 rq 1 rc 2 cq 3 cc
W 0000 00000001 0
R 0000 00000001 0
R 0030 00000000 0
W 0100 89abcdef 0
W 0104 01234567 0
W 0108 20001000 0
W 0110 00000200 0
W 0114 0000005a 0
W 0200 44332211 0
W 0204 0000beef 0
W 0208 30000040 0
W 0210 00000080 0
W 0214 000000a5 0
C 0 5a 0
R 0118 8000005a 0
R 0118 0000005a 0
C 1 a5 0
R 0218 800000a5 0
R 0218 000000a5 0
P 0 4 3
P 1 2 5
P 2 6 2
P 3 1 4
R 0400 00000003 0
R 0404 00000005 0
R 0408 00000002 0
R 040C 00000004 0
E 5 2 0
E 7 1 0
E 0 4 0
E 3 0 0
W 0000 00000000 0
R 0000 00000000 0

//--- sim.f
dma_ctrl_pkg.sv
ctrl_decode.sv
desc_regs.sv
pkt_counters.sv
error_pulse_merge.sv
read_mux.sv
dma_ctrl_core.sv
tb_dma_ctrl_core.sv

//--- Bender.yml
package:
  name: dma_ctrl_core

sources:
  - dma_ctrl_pkg.sv
  - ctrl_decode.sv
  - desc_regs.sv
  - pkt_counters.sv
  - error_pulse_merge.sv
  - read_mux.sv
  - dma_ctrl_core.sv
  - target: simulation
    files:
      - tb_dma_ctrl_core.sv
